//--- hio_params.svh
/*
 * command codes follow the host firmware numbering
 * HIO_CONF_LEN must equal the byte count of HIO_CONF_STR
 * gamma depth is fixed by the 8-bit index in a GAMMA_WR word
 */
`ifndef HIO_PARAMS_SVH
`define HIO_PARAMS_SVH

////////////////////////////////////////////////////////////
// host command codes
////////////////////////////////////////////////////////////
`define HIO_CMD_CFG       8'h01
`define HIO_CMD_JOY0      8'h02
`define HIO_CMD_JOY1      8'h03
`define HIO_CMD_JOY2      8'h16
`define HIO_CMD_JOY3      8'h17
`define HIO_CMD_MOUSE     8'h04
`define HIO_CMD_KBD       8'h05
`define HIO_CMD_OSDKBD    8'h06
`define HIO_CMD_CONF      8'h14
`define HIO_CMD_RTC       8'h22
`define HIO_CMD_VINFO     8'h23
`define HIO_CMD_GAMMA_EN  8'h32
`define HIO_CMD_GAMMA_WR  8'h33

// core configuration string, read back one byte per word
`define HIO_CONF_STR      "RETRO;;T0,Reset;V,v10;"
`define HIO_CONF_LEN      22

// sizes
`define HIO_GAMMA_DEPTH   256
`define HIO_VCNT_W        12

`endif

//--- hio_pkg.sv
/*
 * shared types for the host I/O bridge
 * vcount_t width comes from HIO_VCNT_W
 */
`include "hio_params.svh"

package hio_pkg;

	// one word on the host channel
	typedef logic [15:0] host_word_t;

	// command code, low byte of the first word
	typedef logic [7:0] cmd_t;

	// word position in a frame, 0 is the command word
	typedef logic [9:0] word_idx_t;

	// one colour channel
	typedef logic [7:0] pix_chan_t;

	// pixel or line count from the video meter
	typedef logic [`HIO_VCNT_W-1:0] vcount_t;

	// 0 mouse x, 1 mouse y, 2 keycode, 3 osd key
	typedef logic [1:0] kms_type_t;

	// meter skips the partial frame seen after reset
	typedef enum logic {
		wait_frame,
		measuring
	} meter_state_t;

endpackage

//--- hio_cmd_decoder.sv
/*
 * host transfer decoder, framed by uio_ena, one word per io_strobe
 * word index saturates, so long payloads keep hitting the last slot
 * io_dout answers the strobed word and holds until the next strobe
 */
`include "hio_params.svh"

module hio_cmd_decoder (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  uio_ena,
	input  logic                  io_strobe,
	input  hio_pkg::host_word_t   io_din,
	input  hio_pkg::vcount_t      vinfo_data,
	output hio_pkg::host_word_t   io_dout,
	output hio_pkg::host_word_t   joy0,
	output hio_pkg::host_word_t   joy1,
	output hio_pkg::host_word_t   joy2,
	output hio_pkg::host_word_t   joy3,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output logic                  kms_level,
	output hio_pkg::kms_type_t    kms_type,
	output logic [7:0]            kms_data,
	output logic [2:0]            mouse_buttons,
	output logic [63:0]           rtc,
	output logic [1:0]            vinfo_sel,
	output logic                  gamma_en,
	output logic                  gamma_wr,
	output logic [1:0]            gamma_wr_chan,
	output logic [7:0]            gamma_wr_addr,
	output hio_pkg::pix_chan_t    gamma_wr_data
);

	import hio_pkg::*;

	// string packed with the first character in the top byte
	localparam logic [8*`HIO_CONF_LEN-1:0] conf_str = `HIO_CONF_STR;

	word_idx_t  word_idx;
	cmd_t       cmd;
	logic [1:0] gamma_chan;
	logic [7:0] conf_byte;
	kms_type_t  kms_type_nxt;
	logic       cmd_stb;
	logic       pay_stb;
	logic       kms_evt;

	////////////////////////////////////////////////////////////
	// strobe qualifiers
	////////////////////////////////////////////////////////////
	assign cmd_stb = uio_ena && io_strobe && (word_idx == '0);
	assign pay_stb = uio_ena && io_strobe && (word_idx != '0);

	// keyboard and mouse movement words share one event path
	always_comb begin
		kms_evt      = 1'b0;
		kms_type_nxt = kms_type_t'(2);
		case (cmd)
			`HIO_CMD_KBD: begin
				kms_evt      = pay_stb && (word_idx == 1);
				kms_type_nxt = kms_type_t'(2);
			end
			`HIO_CMD_OSDKBD: begin
				kms_evt      = pay_stb && (word_idx == 1);
				kms_type_nxt = kms_type_t'(3);
			end
			`HIO_CMD_MOUSE: begin
				kms_evt      = pay_stb && (word_idx == 1 || word_idx == 2);
				kms_type_nxt = (word_idx == 1) ? kms_type_t'(0) : kms_type_t'(1);
			end
			default: ;
		endcase
	end

	// config string byte k for payload word k, zero past the end
	always_comb begin
		conf_byte = '0;
		if (word_idx != '0 && word_idx <= word_idx_t'(`HIO_CONF_LEN))
			conf_byte = conf_str[(`HIO_CONF_LEN - int'(word_idx)) * 8 +: 8];
	end

	// meter value k sits at select k-1
	assign vinfo_sel = word_idx[1:0] - 2'd1;

	////////////////////////////////////////////////////////////
	// framing, readback and control registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			word_idx           <= '0;
			cmd                <= '0;
			io_dout            <= '0;
			joy0               <= '0;
			joy1               <= '0;
			joy2               <= '0;
			joy3               <= '0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			kms_level          <= 1'b0;
			mouse_buttons      <= '0;
			gamma_en           <= 1'b0;
			gamma_wr           <= 1'b0;
			gamma_chan         <= '0;
		end else begin
			gamma_wr <= 1'b0;

			if (!uio_ena) begin
				// frame over, next strobe is a command again
				word_idx <= '0;
				cmd      <= '0;
			end else if (io_strobe) begin
				if (word_idx != '1)
					word_idx <= word_idx + 1'b1;
				io_dout <= '0;
			end

			if (cmd_stb) begin
				cmd        <= io_din[7:0];
				gamma_chan <= '0;
				// status readback for the gamma enable command
				if (io_din[7:0] == `HIO_CMD_GAMMA_EN)
					io_dout <= host_word_t'(1);
			end

			if (kms_evt)
				kms_level <= ~kms_level;

			if (pay_stb) begin
				case (cmd)
					`HIO_CMD_CFG:
						if (word_idx == 1) begin
							buttons            <= io_din[1:0];
							forced_scandoubler <= io_din[4];
						end
					`HIO_CMD_JOY0: if (word_idx == 1) joy0 <= io_din;
					`HIO_CMD_JOY1: if (word_idx == 1) joy1 <= io_din;
					`HIO_CMD_JOY2: if (word_idx == 1) joy2 <= io_din;
					`HIO_CMD_JOY3: if (word_idx == 1) joy3 <= io_din;
					`HIO_CMD_MOUSE:
						// third mouse word carries the buttons
						if (word_idx == 3)
							mouse_buttons <= io_din[2:0];
					`HIO_CMD_CONF:
						io_dout <= {8'd0, conf_byte};
					`HIO_CMD_VINFO:
						if (word_idx <= 4)
							io_dout <= host_word_t'(vinfo_data);
					`HIO_CMD_GAMMA_EN:
						if (word_idx == 1)
							gamma_en <= io_din[0];
					`HIO_CMD_GAMMA_WR: begin
						gamma_wr   <= 1'b1;
						// red, green, blue, then back to red
						gamma_chan <= (gamma_chan == 2'd2) ? 2'd0 : gamma_chan + 2'd1;
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// payload registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (kms_evt) begin
			kms_data <= io_din[7:0];
			kms_type <= kms_type_nxt;
		end

		if (pay_stb && cmd == `HIO_CMD_RTC && word_idx <= 4)
			rtc[{word_idx[1:0] - 2'd1, 4'd0} +: 16] <= io_din;

		if (pay_stb && cmd == `HIO_CMD_GAMMA_WR) begin
			gamma_wr_chan <= gamma_chan;
			gamma_wr_addr <= io_din[15:8];
			gamma_wr_data <= io_din[7:0];
		end
	end

	// host may only strobe inside a frame
	a_strobe_in_frame: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		io_strobe |-> uio_ena
	);

	// a table write never targets a fourth channel
	a_gamma_chan: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		gamma_wr |-> (gamma_wr_chan != 2'd3)
	);

endmodule

//--- video_timing_meter.sv
/*
 * measures video timing sampled on ce_pix, all on clk_sys
 * active width is the length of a de run, height the de runs per frame
 * counts latch on each vs rise, the partial first frame is dropped
 */
module video_timing_meter (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic             ce_pix,
	input  logic             de,
	input  logic             hs,
	input  logic             vs,
	input  logic [1:0]       vinfo_sel,
	output hio_pkg::vcount_t vinfo_data
);

	import hio_pkg::*;

	meter_state_t state;
	logic         hs_d;
	logic         vs_d;
	logic         de_d;
	logic         hs_rise;
	logic         vs_rise;
	logic         de_rise;
	logic         de_fall;

	// running counts
	vcount_t pix_cnt;
	vcount_t line_len;
	vcount_t line_cnt;
	vcount_t act_pix;
	vcount_t act_len;
	vcount_t act_lines;

	// frame measurements
	vcount_t m_act_w;
	vcount_t m_act_h;
	vcount_t m_tot_w;
	vcount_t m_tot_h;

	// edges seen on pixel enables only
	assign hs_rise = ce_pix && hs && !hs_d;
	assign vs_rise = ce_pix && vs && !vs_d;
	assign de_rise = ce_pix && de && !de_d;
	assign de_fall = ce_pix && !de && de_d;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state     <= wait_frame;
			hs_d      <= 1'b0;
			vs_d      <= 1'b0;
			de_d      <= 1'b0;
			pix_cnt   <= '0;
			line_len  <= '0;
			line_cnt  <= '0;
			act_pix   <= '0;
			act_len   <= '0;
			act_lines <= '0;
			m_act_w   <= '0;
			m_act_h   <= '0;
			m_tot_w   <= '0;
			m_tot_h   <= '0;
		end else if (ce_pix) begin
			hs_d <= hs;
			vs_d <= vs;
			de_d <= de;

			////////////////////////////////////////////////////////////
			// horizontal
			////////////////////////////////////////////////////////////
			// the hs rise pixel opens the next line
			if (hs_rise) begin
				line_len <= pix_cnt;
				pix_cnt  <= vcount_t'(1);
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end

			if (de_rise)
				act_pix <= vcount_t'(1);
			else if (de)
				act_pix <= act_pix + 1'b1;

			if (de_fall)
				act_len <= act_pix;

			////////////////////////////////////////////////////////////
			// vertical
			////////////////////////////////////////////////////////////
			if (vs_rise) begin
				line_cnt  <= hs_rise ? vcount_t'(1) : '0;
				act_lines <= de_rise ? vcount_t'(1) : '0;
				state     <= measuring;
				if (state == measuring) begin
					m_act_w <= act_len;
					m_act_h <= act_lines;
					m_tot_w <= line_len;
					m_tot_h <= line_cnt;
				end
			end else begin
				if (hs_rise)
					line_cnt <= line_cnt + 1'b1;
				if (de_rise)
					act_lines <= act_lines + 1'b1;
			end
		end
	end

	// host reads one value per payload word
	always_comb begin
		case (vinfo_sel)
			2'd0:    vinfo_data = m_act_w;
			2'd1:    vinfo_data = m_act_h;
			2'd2:    vinfo_data = m_tot_w;
			default: vinfo_data = m_tot_h;
		endcase
	end

	// line or frame longer than the counters can hold
	a_no_wrap: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |-> (hs_rise || pix_cnt != '1) && (vs_rise || line_cnt != '1)
	);

endmodule

//--- gamma_lut.sv
/*
 * three gamma tables, red in pix_in[23:16], blue in pix_in[7:0]
 * one clock from pix_in to pix_out whether enabled or not
 */
`include "hio_params.svh"

module gamma_lut (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               gamma_en,
	input  logic               gamma_wr,
	input  logic [1:0]         gamma_wr_chan,
	input  logic [7:0]         gamma_wr_addr,
	input  hio_pkg::pix_chan_t gamma_wr_data,
	input  logic [23:0]        pix_in,
	output logic [23:0]        pix_out
);

	import hio_pkg::*;

	for (genvar c = 0; c < 3; c++) begin : g_chan
		pix_chan_t tbl [`HIO_GAMMA_DEPTH];
		pix_chan_t raw;

		// channel 0 is the top byte
		assign raw = pix_in[23 - 8*c -: 8];

		// decoder writes one entry per strobe
		always_ff @(posedge clk_sys) begin
			if (gamma_wr && gamma_wr_chan == 2'(c))
				tbl[gamma_wr_addr] <= gamma_wr_data;
		end

		// lookup or bypass, same latency
		always_ff @(posedge clk_sys) begin
			if (!rst_n)
				pix_out[23 - 8*c -: 8] <= '0;
			else
				pix_out[23 - 8*c -: 8] <= gamma_en ? tbl[raw] : raw;
		end
	end

endmodule

//--- hio_subsystem.sv
/*
 * host I/O bridge top, one clock domain on clk_sys
 * gamma table and video meter are reached only through host commands
 */
module hio_subsystem (
	input  logic                clk_sys,
	input  logic                rst_n,
	// host channel
	input  logic                uio_ena,
	input  logic                io_strobe,
	input  hio_pkg::host_word_t io_din,
	output hio_pkg::host_word_t io_dout,
	// video timing and pixels
	input  logic                ce_pix,
	input  logic                de,
	input  logic                hs,
	input  logic                vs,
	input  logic [23:0]         pix_in,
	output logic [23:0]         pix_out,
	// core side
	output hio_pkg::host_word_t joy0,
	output hio_pkg::host_word_t joy1,
	output hio_pkg::host_word_t joy2,
	output hio_pkg::host_word_t joy3,
	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	output logic                kms_level,
	output hio_pkg::kms_type_t  kms_type,
	output logic [7:0]          kms_data,
	output logic [2:0]          mouse_buttons,
	output logic [63:0]         rtc
);

	import hio_pkg::*;

	vcount_t    vinfo_data;
	logic [1:0] vinfo_sel;
	logic       gamma_en;
	logic       gamma_wr;
	logic [1:0] gamma_wr_chan;
	logic [7:0] gamma_wr_addr;
	pix_chan_t  gamma_wr_data;

	hio_cmd_decoder dec_i (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.uio_ena(uio_ena), .io_strobe(io_strobe), .io_din(io_din),
		.vinfo_data(vinfo_data), .io_dout(io_dout),
		.joy0(joy0), .joy1(joy1), .joy2(joy2), .joy3(joy3),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.kms_level(kms_level), .kms_type(kms_type), .kms_data(kms_data),
		.mouse_buttons(mouse_buttons), .rtc(rtc), .vinfo_sel(vinfo_sel),
		.gamma_en(gamma_en), .gamma_wr(gamma_wr), .gamma_wr_chan(gamma_wr_chan),
		.gamma_wr_addr(gamma_wr_addr), .gamma_wr_data(gamma_wr_data)
	);

	video_timing_meter meter_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .ce_pix(ce_pix),
		.de(de), .hs(hs), .vs(vs),
		.vinfo_sel(vinfo_sel), .vinfo_data(vinfo_data)
	);

	gamma_lut gamma_i (
		.clk_sys(clk_sys), .rst_n(rst_n), .gamma_en(gamma_en),
		.gamma_wr(gamma_wr), .gamma_wr_chan(gamma_wr_chan),
		.gamma_wr_addr(gamma_wr_addr), .gamma_wr_data(gamma_wr_data),
		.pix_in(pix_in), .pix_out(pix_out)
	);

endmodule

//--- tb_hio_subsystem.sv
/*
 * directed testbench for the host I/O bridge
 * inputs change 10 units after the rising edge, outputs are read there too
 * the run stops at the first mismatch
 */
`include "hio_params.svh"

module tb_hio_subsystem;

	import hio_pkg::*;

	localparam int clk_period = 100;

	// video raster driven into the meter
	localparam int act_w = 8;
	localparam int tot_w = 12;
	localparam int act_h = 6;
	localparam int tot_h = 9;
	localparam int frame_cycles = tot_w * tot_h;

	// a transfer costs two cycles per word plus three for the frame edges
	localparam int budget_cycles =
		4 +
		5 * (2 * 2 + 3) +
		3 * 3 + 2 * (2 + 2 + 4) +
		2 * (`HIO_CONF_LEN + 3) + 3 +
		2 * 5 + 3 +
		3 * frame_cycles + 1 + 2 * 5 + 3 +
		(2 * 4 + 3) + 2 * (2 * 2 + 3) + 3 * 2;
	localparam int margin_cycles = 200;

	logic        clk_sys;
	logic        rst_n;
	logic        uio_ena;
	logic        io_strobe;
	host_word_t  io_din;
	host_word_t  io_dout;
	logic        ce_pix;
	logic        de;
	logic        hs;
	logic        vs;
	logic [23:0] pix_in;
	logic [23:0] pix_out;
	host_word_t  joy0;
	host_word_t  joy1;
	host_word_t  joy2;
	host_word_t  joy3;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        kms_level;
	kms_type_t   kms_type;
	logic [7:0]  kms_data;
	logic [2:0]  mouse_buttons;
	logic [63:0] rtc;

	integer     seed;
	string      cur_test;
	// payload of the next transfer, and io_dout seen after each word
	host_word_t tx_words [$];
	host_word_t rx_words [0:31];

	hio_subsystem dut_i (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.uio_ena(uio_ena), .io_strobe(io_strobe), .io_din(io_din), .io_dout(io_dout),
		.ce_pix(ce_pix), .de(de), .hs(hs), .vs(vs),
		.pix_in(pix_in), .pix_out(pix_out),
		.joy0(joy0), .joy1(joy1), .joy2(joy2), .joy3(joy3),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.kms_level(kms_level), .kms_type(kms_type), .kms_data(kms_data),
		.mouse_buttons(mouse_buttons), .rtc(rtc)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	task automatic check_eq(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic open_frame();
		@(posedge clk_sys);
		#10;
		uio_ena = 1'b1;
	endtask

	// one extra cycle with uio_ena low so the word index clears
	task automatic close_frame();
		@(posedge clk_sys);
		#10;
		uio_ena = 1'b0;
		@(posedge clk_sys);
		#10;
	endtask

	// one strobe, then io_dout a clock later
	task automatic send_word(input host_word_t w, output host_word_t rd);
		@(posedge clk_sys);
		#10;
		io_strobe = 1'b1;
		io_din    = w;
		@(posedge clk_sys);
		#10;
		io_strobe = 1'b0;
		rd        = io_dout;
	endtask

	task automatic host_xfer(input cmd_t code);
		host_word_t rd;
		int         k;
		open_frame();
		send_word({8'h00, code}, rd);
		rx_words[0] = rd;
		for (k = 0; k < tx_words.size(); k++) begin
			send_word(tx_words[k], rd);
			rx_words[k + 1] = rd;
		end
		close_frame();
	endtask

	// fills tx_words with n random payload words
	task automatic random_payload(input int n);
		int k;
		tx_words.delete();
		for (k = 0; k < n; k++)
			tx_words.push_back(host_word_t'($random(seed)));
	endtask

	task automatic check_event(input host_word_t ev, input kms_type_t typ, input logic lvl_before);
		check_eq("kms_data", 64'(ev[7:0]), 64'(kms_data));
		check_eq("kms_type", 64'(typ), 64'(kms_type));
		check_eq("kms_level toggle", 64'(!lvl_before), 64'(kms_level));
	endtask

	// raster of tot_w x tot_h, active area top left, hs and vs after it
	task automatic run_video(input int frames);
		int f;
		int y;
		int x;
		for (f = 0; f < frames; f++)
			for (y = 0; y < tot_h; y++)
				for (x = 0; x < tot_w; x++) begin
					@(posedge clk_sys);
					#10;
					ce_pix = 1'b1;
					de     = (x < act_w) && (y < act_h);
					hs     = (x >= act_w + 1) && (x < act_w + 3);
					vs     = (y == act_h + 1);
				end
		@(posedge clk_sys);
		#10;
		ce_pix = 1'b0;
		de     = 1'b0;
		hs     = 1'b0;
		vs     = 1'b0;
	endtask

	task automatic drive_pixel(input logic [23:0] p, output logic [23:0] q);
		@(posedge clk_sys);
		#10;
		pix_in = p;
		@(posedge clk_sys);
		#10;
		q = pix_out;
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////
	task automatic write_cfg_joy();
		host_word_t cfg_w;
		host_word_t joy_w [4];
		cmd_t       joy_cmd [4];
		int         n;
		cur_test   = "cfg_joy";
		joy_cmd[0] = `HIO_CMD_JOY0;
		joy_cmd[1] = `HIO_CMD_JOY1;
		joy_cmd[2] = `HIO_CMD_JOY2;
		joy_cmd[3] = `HIO_CMD_JOY3;
		random_payload(1);
		cfg_w = tx_words[0];
		host_xfer(`HIO_CMD_CFG);
		for (n = 0; n < 4; n++) begin
			random_payload(1);
			joy_w[n] = tx_words[0];
			host_xfer(joy_cmd[n]);
		end
		check_eq("buttons", 64'(cfg_w[1:0]), 64'(buttons));
		check_eq("forced_scandoubler", 64'(cfg_w[4]), 64'(forced_scandoubler));
		check_eq("joy0", 64'(joy_w[0]), 64'(joy0));
		check_eq("joy1", 64'(joy_w[1]), 64'(joy1));
		check_eq("joy2", 64'(joy_w[2]), 64'(joy2));
		check_eq("joy3", 64'(joy_w[3]), 64'(joy3));
	endtask

	task automatic send_key_mouse();
		host_word_t rd;
		host_word_t ev;
		logic       lvl;
		int         k;
		cur_test = "kbd_mouse";
		// keycode then osd key, one event word each
		for (k = 0; k < 2; k++) begin
			open_frame();
			send_word({8'h00, (k == 0) ? `HIO_CMD_KBD : `HIO_CMD_OSDKBD}, rd);
			lvl = kms_level;
			ev  = host_word_t'($random(seed));
			send_word(ev, rd);
			check_event(ev, kms_type_t'(k + 2), lvl);
			close_frame();
		end
		// mouse x, mouse y, then buttons
		open_frame();
		send_word({8'h00, `HIO_CMD_MOUSE}, rd);
		for (k = 0; k < 2; k++) begin
			lvl = kms_level;
			ev  = host_word_t'($random(seed));
			send_word(ev, rd);
			check_event(ev, kms_type_t'(k), lvl);
		end
		lvl = kms_level;
		ev  = host_word_t'($random(seed));
		send_word(ev, rd);
		check_eq("kms_level steady", 64'(lvl), 64'(kms_level));
		check_eq("mouse_buttons", 64'(ev[2:0]), 64'(mouse_buttons));
		close_frame();
	endtask

	task automatic read_conf();
		string      text;
		logic [7:0] exp_b;
		int         k;
		cur_test = "conf";
		text     = `HIO_CONF_STR;
		random_payload(`HIO_CONF_LEN + 2);
		host_xfer(`HIO_CMD_CONF);
		// first character is byte 1, zero past the end
		for (k = 1; k <= `HIO_CONF_LEN + 2; k++) begin
			exp_b = (k <= text.len()) ? text[k - 1] : 8'h00;
			check_eq($sformatf("byte %0d", k), 64'(exp_b), 64'(rx_words[k]));
		end
	endtask

	task automatic write_rtc();
		cur_test = "rtc";
		random_payload(4);
		host_xfer(`HIO_CMD_RTC);
		check_eq("rtc", {tx_words[3], tx_words[2], tx_words[1], tx_words[0]}, rtc);
	endtask

	task automatic measure_video();
		cur_test = "vinfo";
		run_video(3);
		random_payload(4);
		host_xfer(`HIO_CMD_VINFO);
		check_eq("active width", 64'(act_w), 64'(rx_words[1]));
		check_eq("active height", 64'(act_h), 64'(rx_words[2]));
		check_eq("total width", 64'(tot_w), 64'(rx_words[3]));
		check_eq("total height", 64'(tot_h), 64'(rx_words[4]));
	endtask

	task automatic gamma_path();
		logic [7:0]  idx;
		pix_chan_t   val [3];
		logic [23:0] raw;
		logic [23:0] got;
		int          c;
		cur_test = "gamma";
		idx      = 8'($random(seed));
		tx_words.delete();
		// words 1, 2, 3 land in red, green, blue
		for (c = 0; c < 3; c++) begin
			val[c] = pix_chan_t'($random(seed));
			tx_words.push_back({idx, val[c]});
		end
		host_xfer(`HIO_CMD_GAMMA_WR);
		tx_words.delete();
		tx_words.push_back(host_word_t'(0));
		host_xfer(`HIO_CMD_GAMMA_EN);
		check_eq("status off", 64'(1), 64'(rx_words[0]));
		raw = 24'($random(seed));
		drive_pixel(raw, got);
		check_eq("bypass random pixel", 64'(raw), 64'(got));
		raw = {idx, idx, idx};
		drive_pixel(raw, got);
		check_eq("bypass pixel", 64'(raw), 64'(got));
		tx_words.delete();
		tx_words.push_back(host_word_t'(1));
		host_xfer(`HIO_CMD_GAMMA_EN);
		check_eq("status on", 64'(1), 64'(rx_words[0]));
		drive_pixel(raw, got);
		check_eq("mapped pixel", 64'({val[0], val[1], val[2]}), 64'(got));
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////
	initial begin
		seed      = 48;
		cur_test  = "reset";
		rst_n     = 1'b0;
		uio_ena   = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
		ce_pix    = 1'b0;
		de        = 1'b0;
		hs        = 1'b0;
		vs        = 1'b0;
		pix_in    = '0;
		repeat (2) @(posedge clk_sys);
		#10;
		rst_n = 1'b1;
		check_eq("io_dout", 64'(0), 64'(io_dout));
		check_eq("kms_level", 64'(0), 64'(kms_level));
		check_eq("buttons", 64'(0), 64'(buttons));
		write_cfg_joy();
		send_key_mouse();
		read_conf();
		write_rtc();
		measure_video();
		gamma_path();
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		#((budget_cycles + margin_cycles) * clk_period);
		$display("timeout: run did not finish within %0d cycles", budget_cycles + margin_cycles);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- hio_subsystem.f
+incdir+.
hio_pkg.sv
hio_cmd_decoder.sv
video_timing_meter.sv
gamma_lut.sv
hio_subsystem.sv
tb_hio_subsystem.sv

//--- Makefile
# Verilator flow for the host I/O bridge, run with e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_hio_subsystem
FILELIST   ?= hio_subsystem.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= TESTS PASSED
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
